/* src/fft_param_pkg.sv */
package fft_param_pkg;

   // ------------------------------
   // transform sizing
   // ------------------------------
   localparam int TRANSFORM_LEN = 256;              // fft points per packet
   localparam int HALF_LEN      = TRANSFORM_LEN / 2; // first mirrored bin

   // ------------------------------
   // data widths
   // ------------------------------
   localparam int ADDR_W = 8;  // one ram word per bin
   localparam int COMP_W = 16; // signed re / im from the core
   localparam int MAG_W  = 32; // stored magnitude word

endpackage

/* src/lcd_param_pkg.sv */
package lcd_param_pkg;

   localparam int PIX_W = 10; // pixel coordinate width
   localparam int RGB_W = 16; // rgb565

   // ------------------------------
   // panel geometry
   // ------------------------------
   localparam logic [PIX_W-1:0] H_DISP = 10'd480;
   localparam logic [PIX_W-1:0] V_DISP = 10'd272;

   // ------------------------------
   // bar placement
   // ------------------------------
   localparam logic [PIX_W-1:0] BAR_X0     = 10'd16;  // column of bin 0
   localparam logic [PIX_W-1:0] BAR_X_END  = 10'd272; // first column past the bars
   localparam logic [PIX_W-1:0] BAR_BASE_Y = 10'd271; // bars grow upward from here
   localparam logic [PIX_W-1:0] REQ_LEAD   = 10'd2;   // read request lead in pixels
   localparam int               MAG_SHIFT  = 8;       // magnitude -> height scale
   localparam logic [PIX_W-1:0] BAR_MAX_H  = 10'd255; // height clip

   // colours, rgb565
   localparam logic [RGB_W-1:0] BAR_COLOR = 16'h07E0; // green
   localparam logic [RGB_W-1:0] BG_COLOR  = 16'h0000; // black

   // per-line drawer sequence
   typedef enum logic [1:0] {
      LINE_IDLE, // waiting for the request lead point
      LINE_BARS, // streaming bins out of the ram
      LINE_TAIL  // all bins requested, waiting for end of line
   } draw_state_t;

endpackage

/* src/fft_magnitude.sv */
`timescale 1ns/1ps

module fft_magnitude import fft_param_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic signed [COMP_W-1:0] fft_re,    // real part of bin
   input  logic signed [COMP_W-1:0] fft_im,    // imag part of bin
   input  logic                     fft_valid,
   input  logic                     fft_eop,   // last bin of packet
   output logic        [MAG_W-1:0]  mag_data,
   output logic                     mag_valid,
   output logic                     mag_eop
);

   // one extra bit so that abs of the most negative value still fits
   logic signed [COMP_W:0]   re_ext;
   logic signed [COMP_W:0]   im_ext;
   logic        [COMP_W:0]   abs_re;
   logic        [COMP_W:0]   abs_im;
   logic        [COMP_W+1:0] abs_sum; // |re| + |im|, carry included

   // ------------------------------
   // |re| + |im|
   // ------------------------------
   assign re_ext = {fft_re[COMP_W-1], fft_re}; // sign extend
   assign im_ext = {fft_im[COMP_W-1], fft_im};

   always_comb begin
      abs_re = re_ext[COMP_W] ? -re_ext : re_ext;
      abs_im = im_ext[COMP_W] ? -im_ext : im_ext;
   end

   assign abs_sum = {1'b0, abs_re} + {1'b0, abs_im};

   // ------------------------------
   // output stage
   // ------------------------------
   // payload word, only loaded with a valid bin
   always_ff @(posedge clk) begin
      if (fft_valid) begin
         mag_data <= MAG_W'(abs_sum); // zero extend
      end
   end

   // strobes follow the data by exactly one clk
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mag_valid <= 1'b0;
         mag_eop   <= 1'b0;
      end else begin
         mag_valid <= fft_valid;
         mag_eop   <= fft_eop & fft_valid; // eop only counts with its bin
      end
   end

endmodule

/* src/dual_clock_ram.sv */
`timescale 1ns/1ps

module dual_clock_ram import fft_param_pkg::*; (
   // write port, fft side
   input  logic              clk,
   input  logic              wr_en,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic [MAG_W-1:0]  wr_data,
   // read port, lcd side
   input  logic              lcd_clk,
   input  logic [ADDR_W-1:0] rd_addr,
   output logic [MAG_W-1:0]  rd_data
);

   // one word per fft bin
   logic [MAG_W-1:0] mem [0:(1 << ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, data one lcd_clk after the address
   always_ff @(posedge lcd_clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/rw_ram_ctrl.sv */
`timescale 1ns/1ps

module rw_ram_ctrl import fft_param_pkg::*; (
   input  logic              clk,
   input  logic              lcd_clk,
   input  logic              rst_n,
   // magnitude stream, clk domain
   input  logic [MAG_W-1:0]  fft_data,
   input  logic              fft_eop,
   input  logic              fft_valid,
   // drawer side, lcd_clk domain
   input  logic              data_req,       // level, one bin per cycle
   input  logic              fft_point_done, // end of line rewind
   output logic [ADDR_W-1:0] fft_point_cnt,  // bins requested this line
   output logic [MAG_W-1:0]  ram_data_out
);

   logic [ADDR_W-1:0] ram_waddr;
   logic [ADDR_W-1:0] ram_raddr;
   logic [MAG_W-1:0]  ram_rd_data;
   logic              data_invalid; // upper half of spectrum reached

   // ------------------------------
   // write side, clk
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ram_waddr <= '0;
      end else if (fft_eop) begin
         ram_waddr <= '0; // last bin is stored at the current address
      end else if (fft_valid) begin
         if (ram_waddr == ADDR_W'(TRANSFORM_LEN - 1)) begin
            ram_waddr <= '0; // packet overrun, wrap
         end else begin
            ram_waddr <= ram_waddr + ADDR_W'(1);
         end
      end
   end

   // ------------------------------
   // read side, lcd_clk
   // ------------------------------
   always_ff @(posedge lcd_clk or negedge rst_n) begin
      if (!rst_n) begin
         ram_raddr     <= '0;
         fft_point_cnt <= '0;
      end else if (fft_point_done) begin
         ram_raddr     <= '0; // back to bin 0 for the next line
         fft_point_cnt <= '0;
      end else if (data_req) begin
         ram_raddr     <= ram_raddr + ADDR_W'(1);
         fft_point_cnt <= fft_point_cnt + ADDR_W'(1);
      end
   end

   // sticky until rewind; lines up with the read data of bin HALF_LEN
   always_ff @(posedge lcd_clk or negedge rst_n) begin
      if (!rst_n) begin
         data_invalid <= 1'b0;
      end else if (fft_point_done) begin
         data_invalid <= 1'b0;
      end else if (ram_raddr == ADDR_W'(HALF_LEN)) begin
         data_invalid <= 1'b1; // mirror image of the lower half
      end
   end

   assign ram_data_out = data_invalid ? '0 : ram_rd_data;

   dual_clock_ram u_ram (
      .clk     (clk),
      .wr_en   (fft_valid),
      .wr_addr (ram_waddr),
      .wr_data (fft_data),
      .lcd_clk (lcd_clk),
      .rd_addr (ram_raddr),
      .rd_data (ram_rd_data)
   );

endmodule

/* src/spectrum_bar_draw.sv */
`timescale 1ns/1ps

module spectrum_bar_draw
   import fft_param_pkg::*;
   import lcd_param_pkg::*;
(
   input  logic              lcd_clk,
   input  logic              rst_n,
   input  logic [PIX_W-1:0]  pixel_x,
   input  logic [PIX_W-1:0]  pixel_y,
   input  logic              lcd_de,
   input  logic [MAG_W-1:0]  ram_data_out,  // bin magnitude, upper half masked
   input  logic [ADDR_W-1:0] fft_point_cnt, // bins requested so far
   output logic              data_req,
   output logic              fft_point_done,
   output logic [RGB_W-1:0]  pixel_rgb
);

   draw_state_t state;
   draw_state_t state_nxt;

   logic [PIX_W-1:0] x_d; // coordinates one cycle late
   logic [PIX_W-1:0] y_d;
   logic             de_d;
   logic             de_fall;
   logic [MAG_W-1:0] mag_shifted;
   logic [PIX_W-1:0] bar_h; // height of the bar for column x_d
   logic             in_area;
   logic             in_cols;
   logic             in_bar;

   assign de_fall = de_d & ~lcd_de; // end of active line

   // ------------------------------
   // line sequencer
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         LINE_IDLE: begin
            if (lcd_de && pixel_x == BAR_X0 - REQ_LEAD) begin
               state_nxt = LINE_BARS; // request ahead of the scan
            end
         end
         LINE_BARS: begin
            if (de_fall) begin
               state_nxt = LINE_IDLE; // short line, give up
            end else if (fft_point_cnt == '1) begin
               state_nxt = LINE_TAIL; // last bin requested this cycle
            end
         end
         LINE_TAIL: begin
            if (de_fall) begin
               state_nxt = LINE_IDLE;
            end
         end
         default: state_nxt = LINE_IDLE;
      endcase
   end

   always_ff @(posedge lcd_clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= LINE_IDLE;
         fft_point_done <= 1'b0;
         de_d           <= 1'b0;
      end else begin
         state          <= state_nxt;
         fft_point_done <= de_fall; // rewind pulse
         de_d           <= lcd_de;
      end
   end

   assign data_req = (state == LINE_BARS);

   // ------------------------------
   // pixel pipeline
   // ------------------------------
   // magnitude to height, clipped at the top
   assign mag_shifted = ram_data_out >> MAG_SHIFT;

   always_ff @(posedge lcd_clk) begin
      x_d <= pixel_x;
      y_d <= pixel_y;
      if (mag_shifted > MAG_W'(BAR_MAX_H)) begin
         bar_h <= BAR_MAX_H;
      end else begin
         bar_h <= PIX_W'(mag_shifted);
      end
   end

   always_comb begin
      in_area = de_d && (x_d < H_DISP) && (y_d < V_DISP);
      in_cols = (x_d >= BAR_X0) && (x_d < BAR_X_END);
      // rows BAR_BASE_Y-bar_h+1 .. BAR_BASE_Y
      in_bar  = (y_d <= BAR_BASE_Y) && ((BAR_BASE_Y - y_d) < bar_h);
   end

   always_ff @(posedge lcd_clk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_rgb <= BG_COLOR;
      end else if (in_area && in_cols && in_bar) begin
         pixel_rgb <= BAR_COLOR;
      end else begin
         pixel_rgb <= BG_COLOR;
      end
   end

endmodule

/* src/spectrum_display_top.sv */
`timescale 1ns/1ps

module spectrum_display_top
   import fft_param_pkg::*;
   import lcd_param_pkg::*;
(
   input  logic                     clk,     // fft side
   input  logic                     lcd_clk, // panel side
   input  logic                     rst_n,
   // fft core output
   input  logic signed [COMP_W-1:0] fft_re,
   input  logic signed [COMP_W-1:0] fft_im,
   input  logic                     fft_valid,
   input  logic                     fft_eop,
   // lcd driver scan
   input  logic        [PIX_W-1:0]  pixel_x,
   input  logic        [PIX_W-1:0]  pixel_y,
   input  logic                     lcd_de,
   output logic        [RGB_W-1:0]  pixel_rgb
);

   // ------------------------------
   // internal nets
   // ------------------------------
   logic [MAG_W-1:0]  mag_data;
   logic              mag_valid;
   logic              mag_eop;
   logic              data_req;
   logic              fft_point_done;
   logic [ADDR_W-1:0] fft_point_cnt;
   logic [MAG_W-1:0]  ram_data_out;

   fft_magnitude u_mag (
      .clk       (clk),
      .rst_n     (rst_n),
      .fft_re    (fft_re),
      .fft_im    (fft_im),
      .fft_valid (fft_valid),
      .fft_eop   (fft_eop),
      .mag_data  (mag_data),
      .mag_valid (mag_valid),
      .mag_eop   (mag_eop)
   );

   // crosses clk -> lcd_clk through the ram
   rw_ram_ctrl u_ram_ctrl (
      .clk            (clk),
      .lcd_clk        (lcd_clk),
      .rst_n          (rst_n),
      .fft_data       (mag_data),
      .fft_eop        (mag_eop),
      .fft_valid      (mag_valid),
      .data_req       (data_req),
      .fft_point_done (fft_point_done),
      .fft_point_cnt  (fft_point_cnt),
      .ram_data_out   (ram_data_out)
   );

   spectrum_bar_draw u_draw (
      .lcd_clk        (lcd_clk),
      .rst_n          (rst_n),
      .pixel_x        (pixel_x),
      .pixel_y        (pixel_y),
      .lcd_de         (lcd_de),
      .ram_data_out   (ram_data_out),
      .fft_point_cnt  (fft_point_cnt),
      .data_req       (data_req),
      .fft_point_done (fft_point_done),
      .pixel_rgb      (pixel_rgb)
   );

endmodule

/* dv/tb_spectrum_display.sv */
`timescale 1ns/1ps

module tb_spectrum_display
   import fft_param_pkg::*;
   import lcd_param_pkg::*;
();

   // ------------------------------
   // run constants
   // ------------------------------
   localparam int LCD_PERIOD   = 20;
   localparam int FFT_PERIOD   = 10;
   localparam int BLANK_CYCLES = 20;                            // idle cycles after each line
   localparam int LINE_CYCLES  = int'(H_DISP) + BLANK_CYCLES;
   localparam int N_LINES      = 19;                            // lines scanned over all tests
   localparam int WATCHDOG_NS  = 2 * N_LINES * LINE_CYCLES * LCD_PERIOD;

   logic                     clk;
   logic                     lcd_clk;
   logic                     rst_n;
   logic signed [COMP_W-1:0] fft_re;
   logic signed [COMP_W-1:0] fft_im;
   logic                     fft_valid;
   logic                     fft_eop;
   logic        [PIX_W-1:0]  pixel_x;
   logic        [PIX_W-1:0]  pixel_y;
   logic                     lcd_de;
   logic        [RGB_W-1:0]  pixel_rgb;

   // frame to send, and magnitudes the ram should hold afterwards
   logic signed [COMP_W-1:0] frame_re  [0:TRANSFORM_LEN-1];
   logic signed [COMP_W-1:0] frame_im  [0:TRANSFORM_LEN-1];
   logic        [MAG_W-1:0]  model_mag [0:TRANSFORM_LEN-1];

   int errors       = 0;
   int checks       = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int err_start;

   spectrum_display_top uut (
      .clk       (clk),
      .lcd_clk   (lcd_clk),
      .rst_n     (rst_n),
      .fft_re    (fft_re),
      .fft_im    (fft_im),
      .fft_valid (fft_valid),
      .fft_eop   (fft_eop),
      .pixel_x   (pixel_x),
      .pixel_y   (pixel_y),
      .lcd_de    (lcd_de),
      .pixel_rgb (pixel_rgb)
   );

   initial begin
      lcd_clk = 1'b0;
      forever #(LCD_PERIOD / 2) lcd_clk = ~lcd_clk;
   end

   initial begin
      clk = 1'b0; // fft side, unrelated to lcd_clk
      forever #(FFT_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // reference model
   // ------------------------------
   // colour of one pixel from the bar rule
   function automatic logic [RGB_W-1:0] expected_rgb(input int x, input int y);
      int k;
      int h;
      k = x - int'(BAR_X0); // bin shown in this column
      if (k < 0 || k >= TRANSFORM_LEN || k >= HALF_LEN) begin
         return BG_COLOR; // outside bars or mirrored half
      end
      h = int'(model_mag[k] >> MAG_SHIFT);
      if (h > int'(BAR_MAX_H)) h = int'(BAR_MAX_H);
      if (y <= int'(BAR_BASE_Y) && (int'(BAR_BASE_Y) - y) < h) begin
         return BAR_COLOR;
      end
      return BG_COLOR;
   endfunction

   task automatic check_rgb(input logic [RGB_W-1:0] exp_rgb, input logic [RGB_W-1:0] act_rgb,
                            input int x, input int y);
      checks++;
      if (act_rgb !== exp_rgb) begin
         errors++;
         $display("[ERROR] %0t: pixel x=%0d y=%0d expected %h got %h",
                  $time, x, y, exp_rgb, act_rgb);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d mismatches", name, errors - err_before);
      end
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   // streams the frame, last bin carries eop
   task automatic send_frame();
      int a_re;
      int a_im;
      for (int i = 0; i < TRANSFORM_LEN; i++) begin
         @(posedge clk);
         fft_re    <= frame_re[i];
         fft_im    <= frame_im[i];
         fft_valid <= 1'b1;
         fft_eop   <= (i == TRANSFORM_LEN - 1);
         a_re = int'(frame_re[i]);
         a_im = int'(frame_im[i]);
         if (a_re < 0) a_re = -a_re;
         if (a_im < 0) a_im = -a_im;
         model_mag[i] = MAG_W'(a_re + a_im);
      end
      @(posedge clk);
      fft_valid <= 1'b0;
      fft_eop   <= 1'b0;
      repeat (3) @(posedge clk); // let the last write land
   endtask

   // one active row then blanking; pixel_rgb lags the coordinate by 2 cycles
   task automatic scan_line(input int row);
      for (int i = 0; i < int'(H_DISP) + 2; i++) begin
         @(posedge lcd_clk);
         if (i < int'(H_DISP)) begin
            pixel_x <= PIX_W'(i);
            pixel_y <= PIX_W'(row);
            lcd_de  <= 1'b1;
         end else begin
            pixel_x <= '0;
            lcd_de  <= 1'b0; // falling de rewinds the read side
         end
         @(negedge lcd_clk);
         if (i >= 2) begin
            check_rgb(expected_rgb(i - 2, row), pixel_rgb, i - 2, row);
         end
      end
      repeat (BLANK_CYCLES - 2) @(posedge lcd_clk);
   endtask

   task automatic fill_zero_frame();
      for (int i = 0; i < TRANSFORM_LEN; i++) begin
         frame_re[i] = '0;
         frame_im[i] = '0;
      end
   endtask

   // full range bins, every fourth one small
   task automatic fill_random_frame();
      for (int i = 0; i < TRANSFORM_LEN; i++) begin
         if (i % 4 == 1) begin
            frame_re[i] = COMP_W'(int'($urandom_range(0, 8191)) - 4096);
            frame_im[i] = COMP_W'(int'($urandom_range(0, 8191)) - 4096);
         end else begin
            frame_re[i] = COMP_W'($urandom);
            frame_im[i] = COMP_W'($urandom);
         end
      end
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   task automatic reset_background();
      err_start = errors;
      @(negedge lcd_clk);
      check_rgb(BG_COLOR, pixel_rgb, 0, 0); // idle output straight after reset
      fill_zero_frame();
      send_frame();
      scan_line(271);
      scan_line(150);
      report_test("reset background", err_start);
   endtask

   task automatic bar_heights();
      err_start = errors;
      fill_random_frame();
      send_frame();
      scan_line(271); // lowest bar row
      scan_line(250);
      scan_line(200);
      scan_line(140);
      scan_line(60);
      scan_line(17);  // top row of a clipped bar
      report_test("bar heights", err_start);
   endtask

   task automatic upper_half_masked();
      err_start = errors;
      fill_random_frame();
      for (int i = HALF_LEN; i < TRANSFORM_LEN; i++) begin
         frame_re[i] = 16'sh8000; // largest magnitude, must stay hidden
         frame_im[i] = 16'sh8000;
      end
      send_frame();
      scan_line(271);
      scan_line(200);
      scan_line(17);
      report_test("upper half masked", err_start);
   endtask

   task automatic line_rewind();
      err_start = errors;
      repeat (3) scan_line(230); // same bars each line
      report_test("line rewind", err_start);
   endtask

   task automatic new_frame_overwrites();
      err_start = errors;
      fill_random_frame();
      send_frame();
      scan_line(271);
      scan_line(180);
      report_test("new frame overwrites", err_start);
   endtask

   task automatic clip_and_outside();
      err_start = errors;
      fill_zero_frame();
      frame_re[0]   = 16'sh8000; // 65536, clipped
      frame_im[0]   = 16'sh8000;
      frame_re[1]   = 16'sh7fff; // 65534, just under the clip
      frame_im[1]   = 16'sh7fff;
      frame_re[2]   = 16'sh8000; // half height
      frame_im[2]   = 16'sh00ff;
      frame_re[127] = 16'sh8000; // last visible column
      frame_im[127] = 16'sh8000;
      frame_re[128] = 16'sh8000;
      frame_re[255] = 16'sh7fff;
      send_frame();
      scan_line(17);  // top of a full bar
      scan_line(16);  // one row above, never drawn
      scan_line(271);
      report_test("clip and outside area", err_start);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      void'($urandom(32'h6eed_344e));
      rst_n     = 1'b0;
      fft_re    = '0;
      fft_im    = '0;
      fft_valid = 1'b0;
      fft_eop   = 1'b0;
      pixel_x   = '0;
      pixel_y   = '0;
      lcd_de    = 1'b0;
      repeat (3) @(posedge lcd_clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge lcd_clk);

      reset_background();
      bar_heights();
      upper_half_masked();
      line_rewind();
      new_frame_overwrites();
      clip_and_outside();

      $display("tests passed %0d, tests failed %0d, pixel checks %0d, mismatches %0d",
               tests_passed, tests_failed, checks, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // hang guard, twice the scanned line time
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

endmodule

/* all.f */
src/fft_param_pkg.sv
src/lcd_param_pkg.sv
src/fft_magnitude.sv
src/dual_clock_ram.sv
src/rw_ram_ctrl.sv
src/spectrum_bar_draw.sv
src/spectrum_display_top.sv
dv/tb_spectrum_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the spectrum display testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps --top-module tb_spectrum_display \
   -f all.f -o sim_tb &&
./obj_dir/sim_tb | grep "Verification passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
